// File: logic/core_pkg.sv
package core_pkg;

    localparam int WORD_W   = 32;
    localparam int PREG_NUM = 64;
    localparam int PREG_W   = $clog2(PREG_NUM);

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [PREG_W-1:0] preg_t;

    // operations of the integer core
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,   // signed compare
        OP_MUL    // low word of the product
    } op_e;

    // selects the issue queue
    typedef enum logic {
        KIND_ALU,
        KIND_MULT
    } kind_e;

endpackage

// File: logic/issue_pkg.sv
package issue_pkg;

    localparam int WAKE_NUM       = 2;
    localparam int WAKE_ALU       = 0;   // results slot of the alu
    localparam int WAKE_MULT      = 1;   // results slot of the multiplier
    localparam int ALU_QUEUE_LEN  = 8;
    localparam int MULT_QUEUE_LEN = 4;
    localparam int IMM_W          = 16;

    typedef logic [IMM_W-1:0] imm_t;

    typedef struct packed {
        logic            ready;
        core_pkg::preg_t tag;
        core_pkg::word_t value;
    } src_t;

    typedef struct packed {
        logic            valid;
        core_pkg::op_e   op;
        core_pkg::kind_e kind;
        core_pkg::preg_t dst;
        core_pkg::preg_t src1;
        core_pkg::preg_t src2;
        logic            use_imm;   // src2 replaced by imm
        imm_t            imm;
    } renamed_t;

    typedef struct packed {
        logic            ready;
        core_pkg::word_t value;
    } prf_read_t;

    typedef struct packed {
        core_pkg::op_e   op;
        core_pkg::preg_t dst;
        src_t            src1;
        src_t            src2;
        imm_t            imm;
    } entry_t;

    typedef struct packed {
        logic            valid;
        core_pkg::kind_e kind;
        entry_t          entry;
    } write_req_t;

    typedef struct packed {
        logic            valid;
        core_pkg::op_e   op;
        core_pkg::preg_t dst;
        core_pkg::word_t opnd1;
        core_pkg::word_t opnd2;
        imm_t            imm;
    } issue_t;

    typedef struct packed {
        logic            valid;
        core_pkg::preg_t tag;
        core_pkg::word_t value;
    } wake_t;

    // a matching broadcast makes the source ready and supplies its value
    function automatic src_t wake_src(src_t src, wake_t [WAKE_NUM-1:0] bus);
        src_t woken;
        woken = src;
        for (int i = 0; i < WAKE_NUM; i++) begin
            if (bus[i].valid && bus[i].tag == src.tag) begin
                woken.ready = 1'b1;
                woken.value = bus[i].value;
            end
        end
        return woken;
    endfunction

endpackage

// File: logic/dispatch_write.sv
`timescale 1ns/100ps

module dispatch_write (
    input  issue_pkg::renamed_t                       renamed,
    input  issue_pkg::prf_read_t                      prf1,
    input  issue_pkg::prf_read_t                      prf2,
    input  issue_pkg::wake_t [issue_pkg::WAKE_NUM-1:0] wakes,
    input  logic                                      alu_full,
    input  logic                                      mult_full,
    output issue_pkg::write_req_t                     write,
    output logic                                      stall
);
    import core_pkg::*;
    import issue_pkg::*;

    src_t  src1_read;
    src_t  src2_read;
    src_t  src1;
    src_t  src2;
    word_t imm_word;
    logic  target_full;

    // register file view of both sources
    always_comb begin
        src1_read.ready = prf1.ready;
        src1_read.tag   = renamed.src1;
        src1_read.value = prf1.value;
        src2_read.ready = prf2.ready;
        src2_read.tag   = renamed.src2;
        src2_read.value = prf2.value;
    end

    assign imm_word = {{(WORD_W-IMM_W){renamed.imm[IMM_W-1]}}, renamed.imm};   // sign extend

    // a result broadcast in this cycle would miss both the read and the queue
    always_comb begin
        src1 = wake_src(src1_read, wakes);
        if (renamed.use_imm) begin
            src2.ready = 1'b1;
            src2.tag   = renamed.src2;
            src2.value = imm_word;
        end else begin
            src2 = wake_src(src2_read, wakes);
        end
    end

    assign target_full = (renamed.kind == KIND_MULT) ? mult_full : alu_full;
    assign stall       = renamed.valid && target_full;

    always_comb begin
        write.valid      = renamed.valid && !target_full;
        write.kind       = renamed.kind;
        write.entry.op   = renamed.op;
        write.entry.dst  = renamed.dst;
        write.entry.src1 = src1;
        write.entry.src2 = src2;
        write.entry.imm  = renamed.imm;
    end

endmodule

// File: logic/issue_queue.sv
`timescale 1ns/100ps

module issue_queue #(
    parameter int              QUEUE_LEN = 8,
    parameter core_pkg::kind_e KIND      = core_pkg::KIND_ALU
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  issue_pkg::write_req_t                     write,
    input  issue_pkg::wake_t [issue_pkg::WAKE_NUM-1:0] wakes,
    output logic                                      full,
    output issue_pkg::issue_t                         issued
);
    import core_pkg::*;
    import issue_pkg::*;

    entry_t               entries [QUEUE_LEN];
    logic [QUEUE_LEN-1:0] valid;
    logic [QUEUE_LEN-1:0] older [QUEUE_LEN];   // older[i][j] set when slot j came before slot i
    logic [QUEUE_LEN-1:0] ready_vec;
    logic [QUEUE_LEN-1:0] sel_oh;
    logic [QUEUE_LEN-1:0] alloc_oh;
    logic                 accept;

    assign full   = &valid;
    assign accept = write.valid && (write.kind == KIND) && !full;

    always_comb begin
        for (int i = 0; i < QUEUE_LEN; i++) begin
            ready_vec[i] = valid[i] && entries[i].src1.ready && entries[i].src2.ready;
        end
    end

    // oldest ready: no other ready slot is older
    always_comb begin
        for (int i = 0; i < QUEUE_LEN; i++) begin
            sel_oh[i] = ready_vec[i] && ((older[i] & ready_vec) == '0);
        end
    end

    // lowest free slot
    always_comb begin
        alloc_oh = '0;
        for (int i = QUEUE_LEN - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                alloc_oh    = '0;
                alloc_oh[i] = 1'b1;
            end
        end
    end

    always_comb begin
        issued = '0;
        for (int i = 0; i < QUEUE_LEN; i++) begin
            if (sel_oh[i]) begin
                issued.valid = 1'b1;
                issued.op    = entries[i].op;
                issued.dst   = entries[i].dst;
                issued.opnd1 = entries[i].src1.value;
                issued.opnd2 = entries[i].src2.value;   // holds the imm when used
                issued.imm   = entries[i].imm;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else begin
            valid <= (valid & ~sel_oh) | (accept ? alloc_oh : '0);
        end
    end

    // a new entry is younger than every entry that stays
    always_ff @(posedge clk) begin
        for (int i = 0; i < QUEUE_LEN; i++) begin
            if (rst) begin
                older[i] <= '0;
            end else if (accept && alloc_oh[i]) begin
                older[i] <= valid & ~sel_oh;
            end else if (accept) begin
                older[i] <= older[i] & ~alloc_oh;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < QUEUE_LEN; i++) begin
            if (accept && alloc_oh[i]) begin
                entries[i] <= write.entry;   // already merged with this cycle's wakes
            end else begin
                if (!entries[i].src1.ready) begin
                    entries[i].src1 <= wake_src(entries[i].src1, wakes);
                end
                if (!entries[i].src2.ready) begin
                    entries[i].src2 <= wake_src(entries[i].src2, wakes);
                end
            end
        end
    end

    // the dispatch side must hold its write back while this queue is full
    a_no_write_when_full: assert property (@(posedge clk) disable iff (rst)
        (write.valid && write.kind == KIND) |-> !full);

    // age order stays total, so exactly one ready slot wins
    a_issue_onehot: assert property (@(posedge clk) disable iff (rst)
        issued.valid |-> $onehot(sel_oh));

endmodule

// File: logic/exec_unit.sv
`timescale 1ns/100ps

module exec_unit (
    input  logic                                      clk,
    input  logic                                      rst,
    input  issue_pkg::issue_t                         alu_op,
    input  issue_pkg::issue_t                         mult_op,
    output issue_pkg::wake_t [issue_pkg::WAKE_NUM-1:0] results
);
    import core_pkg::*;
    import issue_pkg::*;

    word_t alu_value;
    word_t mult_value;
    logic  alu_less;

    assign alu_less = $signed(alu_op.opnd1) < $signed(alu_op.opnd2);

    always_comb begin
        case (alu_op.op)
            OP_ADD:  alu_value = alu_op.opnd1 + alu_op.opnd2;
            OP_SUB:  alu_value = alu_op.opnd1 - alu_op.opnd2;
            OP_AND:  alu_value = alu_op.opnd1 & alu_op.opnd2;
            OP_OR:   alu_value = alu_op.opnd1 | alu_op.opnd2;
            OP_XOR:  alu_value = alu_op.opnd1 ^ alu_op.opnd2;
            OP_SLT:  alu_value = {{(WORD_W-1){1'b0}}, alu_less};
            default: alu_value = '0;   // mul never routed here
        endcase
    end

    assign mult_value = mult_op.opnd1 * mult_op.opnd2;   // low word only

    always_ff @(posedge clk) begin
        results[WAKE_ALU].tag    <= alu_op.dst;
        results[WAKE_ALU].value  <= alu_value;
        results[WAKE_MULT].tag   <= mult_op.dst;
        results[WAKE_MULT].value <= mult_value;
        if (rst) begin
            results[WAKE_ALU].valid  <= 1'b0;
            results[WAKE_MULT].valid <= 1'b0;
        end else begin
            results[WAKE_ALU].valid  <= alu_op.valid;
            results[WAKE_MULT].valid <= mult_op.valid;
        end
    end

    // routing by kind in dispatch keeps other ops off the multiplier
    a_mult_only_mul: assert property (@(posedge clk) disable iff (rst)
        mult_op.valid |-> mult_op.op == OP_MUL);

endmodule

// File: logic/issue_top.sv
`timescale 1ns/100ps

module issue_top (
    input  logic                                      clk,
    input  logic                                      rst,
    input  issue_pkg::renamed_t                       renamed,
    input  issue_pkg::prf_read_t                      prf1,
    input  issue_pkg::prf_read_t                      prf2,
    output logic                                      stall,
    output issue_pkg::wake_t [issue_pkg::WAKE_NUM-1:0] results
);
    import core_pkg::*;
    import issue_pkg::*;

    write_req_t write;
    logic       alu_full;
    logic       mult_full;
    issue_t     alu_issued;
    issue_t     mult_issued;

    dispatch_write dispatch0 (
        .renamed   (renamed),
        .prf1      (prf1),
        .prf2      (prf2),
        .wakes     (results),
        .alu_full  (alu_full),
        .mult_full (mult_full),
        .write     (write),
        .stall     (stall)
    );

    issue_queue #(
        .QUEUE_LEN (ALU_QUEUE_LEN),
        .KIND      (KIND_ALU)
    ) alu_queue (
        .clk    (clk),
        .rst    (rst),
        .write  (write),
        .wakes  (results),
        .full   (alu_full),
        .issued (alu_issued)
    );

    issue_queue #(
        .QUEUE_LEN (MULT_QUEUE_LEN),
        .KIND      (KIND_MULT)
    ) mult_queue (
        .clk    (clk),
        .rst    (rst),
        .write  (write),
        .wakes  (results),
        .full   (mult_full),
        .issued (mult_issued)
    );

    exec_unit exec0 (
        .clk     (clk),
        .rst     (rst),
        .alu_op  (alu_issued),
        .mult_op (mult_issued),
        .results (results)
    );

endmodule

// File: verification/issue_model.svh
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

localparam int INIT_REGS  = 8;   // tags 0..7 hold ready values from the start
localparam int RECENT_NUM = 4;

word_t reg_value [PREG_NUM];   // register file contents as results arrive
logic  reg_ready [PREG_NUM];
word_t golden    [PREG_NUM];   // in-order value of the latest producer of each tag
logic  pending   [PREG_NUM];
logic  seen      [PREG_NUM];
preg_t recent    [$];
preg_t next_tag;
int    outstanding;

task automatic init_model();
    for (int t = 0; t < PREG_NUM; t++) begin
        reg_value[t] = (t < INIT_REGS) ? $urandom : 32'h0;
        reg_ready[t] = (t < INIT_REGS);
        golden[t]    = reg_value[t];
        pending[t]   = 1'b0;
        seen[t]      = 1'b0;
    end
    recent.delete();
    next_tag    = preg_t'(INIT_REGS);
    outstanding = 0;
endtask

function automatic word_t sext_imm(imm_t imm);
    return {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm};
endfunction

function automatic word_t op_rule(op_e op, word_t a, word_t b);
    case (op)
        OP_ADD:  return a + b;
        OP_SUB:  return a - b;
        OP_AND:  return a & b;
        OP_OR:   return a | b;
        OP_XOR:  return a ^ b;
        OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        default: return a * b;
    endcase
endfunction

// destinations rotate over the tags above the initial registers
function automatic void advance_tag();
    next_tag = (next_tag == PREG_W'(PREG_NUM - 1)) ? preg_t'(INIT_REGS) : preg_t'(next_tag + 1);
endfunction

function automatic preg_t pick_src(logic dependent);
    if (dependent && recent.size() > 0 && $urandom_range(3, 0) != 0) begin
        return recent[$urandom_range(recent.size() - 1, 0)];
    end
    return preg_t'($urandom_range(INIT_REGS - 1, 0));
endfunction

function automatic void record_dispatch(preg_t dst, op_e op, word_t a, word_t b);
    golden[dst]    = op_rule(op, a, b);
    pending[dst]   = 1'b1;
    seen[dst]      = 1'b0;
    reg_ready[dst] = 1'b0;
    outstanding++;
    recent.push_back(dst);
    if (recent.size() > RECENT_NUM) begin
        void'(recent.pop_front());
    end
endfunction

`endif

// File: verification/issue_tb.sv
`timescale 1ns/100ps

module issue_tb;
    import core_pkg::*;
    import issue_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 3;
    localparam int DRIVE_DELAY     = 2;
    localparam int PROG_LEN        = 200;
    localparam int WATCHDOG_CYCLES = PROG_LEN * 20;
    localparam int DRAIN_CYCLES    = (ALU_QUEUE_LEN + MULT_QUEUE_LEN) * 8;

    logic                 clk;
    logic                 rst;
    renamed_t             renamed;
    prf_read_t            prf1;
    prf_read_t            prf2;
    logic                 stall;
    wake_t [WAKE_NUM-1:0] results;
    int                   error_count;
    int                   check_count;
    int                   test_count;
    int                   test_fail;
    logic                 stall_seen;

    `include "issue_model.svh"

    issue_top dut0 (
        .clk     (clk),
        .rst     (rst),
        .renamed (renamed),
        .prf1    (prf1),
        .prf2    (prf2),
        .stall   (stall),
        .results (results)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(string name, word_t actual, word_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic drive_reads();   // register file read port
        prf1.ready = reg_ready[renamed.src1];
        prf1.value = reg_value[renamed.src1];
        prf2.ready = reg_ready[renamed.src2];
        prf2.value = reg_value[renamed.src2];
    endtask

    task automatic dispatch(op_e op, preg_t src1, preg_t src2, logic use_imm, imm_t imm);
        logic accepted;
        while (pending[next_tag]) begin   // tag still in flight
            renamed.valid = 1'b0;
            @(posedge clk);
            #DRIVE_DELAY;
        end
        renamed = {1'b1, op, (op == OP_MUL) ? KIND_MULT : KIND_ALU, next_tag, src1, src2,
                   use_imm, imm};
        record_dispatch(next_tag, op, golden[src1], use_imm ? sext_imm(imm) : golden[src2]);
        advance_tag();
        accepted = 1'b0;
        while (!accepted) begin
            drive_reads();
            @(negedge clk);
            accepted = !stall;
            stall_seen = stall_seen | stall;
            @(posedge clk);
            #DRIVE_DELAY;
        end
        renamed.valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        renamed.valid = 1'b0;
        waited = 0;
        while (outstanding != 0 && waited < DRAIN_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        @(posedge clk);
        #DRIVE_DELAY;
        if (outstanding != 0) begin
            error_count++;
            $display("%0d results still missing after the queues drained", outstanding);
        end
    endtask

    task automatic finish_test(string name, int errors_before);
        test_count++;
        if (error_count != errors_before) begin
            test_fail++;
            $display("test %s: failed with %0d errors", name, error_count - errors_before);
        end else begin
            $display("test %s: passed", name);
        end
    endtask

    // results seen mid-cycle update the register file model
    always @(negedge clk) begin
        preg_t tag;
        if (!rst) begin
            for (int w = 0; w < WAKE_NUM; w++) begin
                tag = results[w].tag;
                if (results[w].valid && seen[tag]) begin
                    error_count++;
                    $display("result for tag %0d appeared a second time", tag);
                end else if (results[w].valid && !pending[tag]) begin
                    error_count++;
                    $display("result for tag %0d arrived while none was expected", tag);
                end else if (results[w].valid) begin
                    check_value($sformatf("results[%0d].value tag %0d", w, tag),
                                results[w].value, golden[tag]);
                    pending[tag] = 1'b0;
                    seen[tag]    = 1'b1;
                    outstanding--;
                end
                if (results[w].valid) begin
                    reg_value[tag] = results[w].value;
                    reg_ready[tag] = 1'b1;
                end
            end
        end
    end

    initial begin
        int    errors_before;
        preg_t chain;
        clk = 1'b0;
        rst = 1'b1;
        renamed = '0;
        prf1 = '0;
        prf2 = '0;
        error_count = 0;
        check_count = 0;
        test_count = 0;
        test_fail = 0;
        stall_seen = 1'b0;
        void'($urandom(32'h1311_e53d));
        init_model();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        errors_before = error_count;
        @(negedge clk);
        check_value("results[0].valid", word_t'(results[WAKE_ALU].valid), 32'h0);
        check_value("results[1].valid", word_t'(results[WAKE_MULT].valid), 32'h0);
        check_value("stall", word_t'(stall), 32'h0);
        @(posedge clk);
        #DRIVE_DELAY;
        finish_test("reset state", errors_before);

        errors_before = error_count;
        for (int i = 0; i < 40; i++) begin
            dispatch(op_e'($urandom_range(5, 0)), pick_src(1'b0), pick_src(1'b0),
                     1'($urandom_range(1, 0)), imm_t'($urandom));
        end
        drain();
        finish_test("independent alu", errors_before);

        errors_before = error_count;
        for (int i = 0; i < 60; i++) begin
            dispatch(op_e'($urandom_range(6, 0)), pick_src(1'b1), pick_src(1'b1), 1'b0, '0);
        end
        drain();
        finish_test("dependent chains", errors_before);

        errors_before = error_count;
        for (int i = 0; i < 60; i++) begin   // walks every opcode in turn
            dispatch(op_e'(i % 7), pick_src(1'b1), pick_src(1'b1),
                     1'($urandom_range(1, 0)), imm_t'($urandom));
        end
        drain();
        finish_test("immediates and opcodes", errors_before);

        errors_before = error_count;
        stall_seen = 1'b0;
        chain = pick_src(1'b0);
        for (int i = 0; i < 40; i++) begin   // each mul waits on the one before
            dispatch(OP_MUL, chain, pick_src(1'b0), 1'b0, '0);
            chain = recent[$];
        end
        drain();
        if (!stall_seen) begin
            error_count++;
            $display("stall never rose while the multiply queue was filling");
        end
        finish_test("multiply queue full", errors_before);

        errors_before = error_count;
        for (int t = 0; t < PREG_NUM; t++) begin
            if (pending[t]) begin
                error_count++;
                $display("tag %0d was dispatched but its result never appeared", t);
            end
        end
        finish_test("all tags returned", errors_before);

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_count, test_fail, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (WATCHDOG_CYCLES + RESET_CYCLES));
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+verification
logic/core_pkg.sv
logic/issue_pkg.sv
logic/dispatch_write.sv
logic/issue_queue.sv
logic/exec_unit.sv
logic/issue_top.sv
verification/issue_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module issue_tb \
    -f verilog.f -Mdir obj_dir -o issue_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/issue_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "CHECKS FAILED" sim.log; then
    exit 1
fi
exit 0
